/* hw/floor_pkg.sv */
// Floor request package with floor sizes, the floor type and the car motion states
package floor_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int NUM_FLOORS  = 11;
    localparam int FLOOR_W     = 4;
    localparam int STACK_DEPTH = 11;

    // Stack pointer runs from 0 (empty) to STACK_DEPTH (full)
    localparam int PTR_W       = $clog2(STACK_DEPTH + 1);

    // Floor number, 0 is the ground floor
    typedef logic [FLOOR_W-1:0] floor_t;

    ////////////////////////////////////////////////////////////////////////////
    // Motion controller state
    ////////////////////////////////////////////////////////////////////////////

    // Stop states first so that a single compare finds them
    typedef enum logic [5:0] {
        STOP_FL1 = 6'd0,
        STOP_FL2, STOP_FL3, STOP_FL4, STOP_FL5, STOP_FL6,
        STOP_FL7, STOP_FL8, STOP_FL9, STOP_FL10, STOP_FL11,
        // Travelling up between two floors
        UP_F1_F2 = 6'd11,
        UP_F2_F3, UP_F3_F4, UP_F4_F5, UP_F5_F6, UP_F6_F7,
        UP_F7_F8, UP_F8_F9, UP_F9_F10, UP_F10_F11,
        // Travelling down between two floors
        DOWN_F11_F10 = 6'd21,
        DOWN_F10_F9, DOWN_F9_F8, DOWN_F8_F7, DOWN_F7_F6,
        DOWN_F6_F5, DOWN_F5_F4, DOWN_F4_F3, DOWN_F3_F2, DOWN_F2_F1,
        EMERGENCY = 6'd31
    } car_state_t;

    // True when the car stands at a floor
    function automatic logic is_stop_state(car_state_t state);
        return state <= STOP_FL11;
    endfunction

endpackage

/* hw/request_if.sv */
// Request bus between the light, stack and dispatch blocks
`timescale 1ns/1ps

interface request_if;

    // From the light block
    logic              push;
    floor_pkg::floor_t push_floor;
    logic              flush;

    // From the stack
    floor_pkg::floor_t top_floor;
    logic              empty;
    logic              full;

    // From dispatch
    logic              pop;
    logic              car_stopped;

    modport lights (
        output push, push_floor, flush,
        input  full, car_stopped
    );

    modport stack (
        input  push, push_floor, pop, flush,
        output top_floor, empty, full
    );

    modport dispatch (
        input  top_floor, empty, flush,
        output pop, car_stopped
    );

endinterface

/* hw/request_lights.sv */
// Button acceptance into hall and panel lights, with the flush condition
`timescale 1ns/1ps

module request_lights (
    input  logic                             clock,
    input  logic                             reset_n,
    input  logic [floor_pkg::NUM_FLOORS-1:0] call_buttons,
    input  logic [floor_pkg::NUM_FLOORS-1:0] panel_buttons,
    input  logic                             power_switch,
    input  logic                             emergency,
    input  floor_pkg::floor_t                current_floor,
    request_if.lights                        req,
    output logic [floor_pkg::NUM_FLOORS-1:0] call_lights,
    output logic [floor_pkg::NUM_FLOORS-1:0] panel_lights
);

    logic [floor_pkg::NUM_FLOORS-1:0] cur_mask;
    logic [floor_pkg::NUM_FLOORS-1:0] panel_cand;
    logic [floor_pkg::NUM_FLOORS-1:0] call_cand;
    logic [floor_pkg::NUM_FLOORS-1:0] accept_mask;
    logic [floor_pkg::NUM_FLOORS-1:0] clear_mask;
    logic                             use_panel;
    logic                             accept;
    floor_pkg::floor_t                accept_floor;

    // Lowest set bit of a button vector
    function automatic floor_pkg::floor_t lowest_set(logic [floor_pkg::NUM_FLOORS-1:0] vec);
        floor_pkg::floor_t idx;
        idx = '0;
        for (int i = floor_pkg::NUM_FLOORS - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = floor_pkg::floor_t'(i);
            end
        end
        return idx;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Acceptance
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        cur_mask = '0;
        if (current_floor < floor_pkg::NUM_FLOORS) begin
            cur_mask[current_floor] = 1'b1;
        end
    end

    // Power off or emergency flushes the whole request path
    assign req.flush = !power_switch || emergency;

    // Candidates are pressed, not yet lit, and not the floor the car is at
    assign panel_cand = panel_buttons & ~panel_lights & ~cur_mask;
    assign call_cand  = call_buttons & ~call_lights & ~cur_mask;

    // Panel wins; a passed-over hall press stays unlit and is retried
    assign use_panel    = |panel_cand;
    assign accept       = !req.flush && (use_panel || |call_cand);
    assign accept_floor = use_panel ? lowest_set(panel_cand) : lowest_set(call_cand);

    always_comb begin
        accept_mask = '0;
        accept_mask[accept_floor] = accept;
    end

    // Stack ignores a push when full, so hold it back here as well
    assign req.push       = accept && !req.full;
    assign req.push_floor = accept_floor;

    ////////////////////////////////////////////////////////////////////////////
    // Light registers
    ////////////////////////////////////////////////////////////////////////////

    assign clear_mask = req.car_stopped ? cur_mask : '0;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            panel_lights <= '0;
            call_lights  <= '0;
        end else if (req.flush) begin
            panel_lights <= '0;
            call_lights  <= '0;
        end else begin
            panel_lights <= (panel_lights | (use_panel ? accept_mask : '0)) & ~clear_mask;
            call_lights  <= (call_lights | (use_panel ? '0 : accept_mask)) & ~clear_mask;
        end
    end

    // A pushed floor shows its light after the edge
    a_push_sets_light: assert property (
        @(posedge clock) disable iff (!reset_n)
        req.push |=> (panel_lights[$past(req.push_floor)]
                      || call_lights[$past(req.push_floor)])
    ) else $error("pushed floor has no light on");

endmodule

/* hw/floor_stack.sv */
// Last-in-first-out store of requested floors with full and empty flags
`timescale 1ns/1ps

module floor_stack (
    input  logic      clock,
    input  logic      reset_n,
    request_if.stack  req
);

    floor_pkg::floor_t               entries [floor_pkg::STACK_DEPTH];
    logic [floor_pkg::PTR_W-1:0]     ptr;
    logic [floor_pkg::PTR_W-1:0]     ptr_pop;
    logic                            do_pop;
    logic                            do_push;

    ////////////////////////////////////////////////////////////////////////////
    // Pointer update, pop first then push
    ////////////////////////////////////////////////////////////////////////////

    assign do_pop  = req.pop && !req.empty;
    assign ptr_pop = ptr - floor_pkg::PTR_W'(do_pop);

    // A push fits if the pop in the same cycle made room
    assign do_push = req.push && (ptr_pop < floor_pkg::STACK_DEPTH);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ptr <= '0;
        end else if (req.flush) begin
            ptr <= '0;
        end else begin
            ptr <= ptr_pop + floor_pkg::PTR_W'(do_push);
        end
    end

    // Entries above the pointer are dead and never read
    always_ff @(posedge clock) begin
        if (do_push && !req.flush) begin
            entries[ptr_pop] <= req.push_floor;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Status
    ////////////////////////////////////////////////////////////////////////////

    assign req.empty     = (ptr == '0);
    assign req.full      = (ptr == floor_pkg::PTR_W'(floor_pkg::STACK_DEPTH));
    assign req.top_floor = req.empty ? '0 : entries[ptr - 1'b1];

    a_ptr_in_range: assert property (
        @(posedge clock) disable iff (!reset_n) ptr <= floor_pkg::STACK_DEPTH
    ) else $error("stack pointer out of range: %0d", ptr);

endmodule

/* hw/car_dispatch.sv */
// Target floor selection, direction, activate, pop on arrival and door permits
`timescale 1ns/1ps

module car_dispatch (
    input  floor_pkg::floor_t     current_floor,
    input  floor_pkg::car_state_t car_state,
    input  logic                  door_open_btn,
    input  logic                  door_close_btn,
    request_if.dispatch           req,
    output floor_pkg::floor_t     target_floor,
    output logic                  direction_up,
    output logic                  activate,
    output logic                  door_open_allowed,
    output logic                  door_close_allowed
);

    logic              stopped;
    logic              live;
    floor_pkg::floor_t target;

    ////////////////////////////////////////////////////////////////////////////
    // Target
    ////////////////////////////////////////////////////////////////////////////

    assign stopped         = floor_pkg::is_stop_state(car_state);
    assign req.car_stopped = stopped;

    // Stack top is a real request only when something is stored and no flush
    assign live = !req.empty && !req.flush;

    // Without a request the target just reads back the current floor
    assign target       = live ? req.top_floor : current_floor;
    assign target_floor = target;

    assign direction_up = target > current_floor;

    // Start the car only from a stop and only toward another floor
    assign activate = stopped && !req.flush && (target != current_floor);

    ////////////////////////////////////////////////////////////////////////////
    // Arrival
    ////////////////////////////////////////////////////////////////////////////

    // Standing at the requested floor retires the top entry
    assign req.pop = stopped && live && (req.top_floor == current_floor);

    ////////////////////////////////////////////////////////////////////////////
    // Doors
    ////////////////////////////////////////////////////////////////////////////

    // Doors only while standing, and never during power loss or emergency
    assign door_open_allowed  = door_open_btn && stopped && !req.flush;
    assign door_close_allowed = door_close_btn && stopped && !req.flush;

endmodule

/* hw/floor_request_top.sv */
// Floor request controller top level joining lights, request stack and dispatch
`timescale 1ns/1ps

module floor_request_top (
    input  logic                             clock,
    input  logic                             reset_n,
    input  logic [floor_pkg::NUM_FLOORS-1:0] call_buttons,
    input  logic [floor_pkg::NUM_FLOORS-1:0] panel_buttons,
    input  logic                             door_open_btn,
    input  logic                             door_close_btn,
    input  logic                             emergency,
    input  logic                             power_switch,
    input  floor_pkg::floor_t                current_floor,
    input  floor_pkg::car_state_t            car_state,
    output floor_pkg::floor_t                target_floor,
    output logic                             direction_up,
    output logic                             activate,
    output logic [floor_pkg::NUM_FLOORS-1:0] call_lights,
    output logic [floor_pkg::NUM_FLOORS-1:0] panel_lights,
    output logic                             door_open_allowed,
    output logic                             door_close_allowed
);

    request_if req ();

    // Buttons in, lights out, push and flush onto the bus
    request_lights u_lights (
        .clock         (clock),
        .reset_n       (reset_n),
        .call_buttons  (call_buttons),
        .panel_buttons (panel_buttons),
        .power_switch  (power_switch),
        .emergency     (emergency),
        .current_floor (current_floor),
        .req           (req.lights),
        .call_lights   (call_lights),
        .panel_lights  (panel_lights)
    );

    floor_stack u_stack (
        .clock   (clock),
        .reset_n (reset_n),
        .req     (req.stack)
    );

    // Talks to the motion controller
    car_dispatch u_dispatch (
        .current_floor      (current_floor),
        .car_state          (car_state),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .req                (req.dispatch),
        .target_floor       (target_floor),
        .direction_up       (direction_up),
        .activate           (activate),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

/* sim/tb_floor_request.sv */
// Floor request controller testbench with directed tests for lights, stack order, flush and doors
`timescale 1ns/1ps

module tb_floor_request;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 3;
    localparam int DOOR_ITERS    = 40;
    // Cycles used by the directed tests, door loop included
    localparam int TEST_CYCLES   = RESET_CYCLES + 40 + DOOR_ITERS;
    localparam int MARGIN_CYCLES = 50;

    logic                             clock;
    logic                             reset_n;
    logic [floor_pkg::NUM_FLOORS-1:0] call_buttons;
    logic [floor_pkg::NUM_FLOORS-1:0] panel_buttons;
    logic                             door_open_btn;
    logic                             door_close_btn;
    logic                             emergency;
    logic                             power_switch;
    floor_pkg::floor_t                current_floor;
    floor_pkg::car_state_t            car_state;
    floor_pkg::floor_t                target_floor;
    logic                             direction_up;
    logic                             activate;
    logic [floor_pkg::NUM_FLOORS-1:0] call_lights;
    logic [floor_pkg::NUM_FLOORS-1:0] panel_lights;
    logic                             door_open_allowed;
    logic                             door_close_allowed;

    integer seed;
    int     check_count;
    int     error_count;
    int     test_count;

    floor_request_top UUT (
        .clock              (clock),
        .reset_n            (reset_n),
        .call_buttons       (call_buttons),
        .panel_buttons      (panel_buttons),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .emergency          (emergency),
        .power_switch       (power_switch),
        .current_floor      (current_floor),
        .car_state          (car_state),
        .target_floor       (target_floor),
        .direction_up       (direction_up),
        .activate           (activate),
        .call_lights        (call_lights),
        .panel_lights       (panel_lights),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // Watchdog
    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        $display("TEST FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [floor_pkg::NUM_FLOORS-1:0] one_hot(int f);
        logic [floor_pkg::NUM_FLOORS-1:0] v;
        v = '0;
        v[f] = 1'b1;
        return v;
    endfunction

    task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("ERR %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // Next falling edge, one rising edge later
    task automatic step_cycle();
        @(posedge clock);
        @(negedge clock);
    endtask

    // Lets combinational outputs settle after a drive
    task automatic settle();
        #1;
    endtask

    // Stop state values equal the floor number
    task automatic stop_at(input int f);
        current_floor = floor_pkg::floor_t'(f);
        car_state     = floor_pkg::car_state_t'(f);
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("%-16s %s, %0d errors", name,
                 (error_count == errors_before) ? "ok" : "failed",
                 error_count - errors_before);
    endtask

    task automatic check_idle(input int f);
        check_eq("target_floor", target_floor, f);
        check_eq("activate", activate, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic after_reset();
        int start;
        start = error_count;
        stop_at(3);
        settle();
        check_eq("call_lights", call_lights, '0);
        check_eq("panel_lights", panel_lights, '0);
        check_idle(3);
        check_eq("door_open_allowed", door_open_allowed, 1'b0);
        check_eq("door_close_allowed", door_close_allowed, 1'b0);
        step_cycle();
        report_test("after_reset", start);
    endtask

    task automatic single_request();
        int start;
        start = error_count;
        stop_at(2);
        panel_buttons = one_hot(7);
        step_cycle();
        panel_buttons = '0;
        settle();
        check_eq("panel_lights", panel_lights, one_hot(7));
        check_eq("target_floor", target_floor, 7);
        check_eq("activate", activate, 1'b1);
        check_eq("direction_up", direction_up, 1'b1);
        // Arrival at floor 7
        step_cycle();
        stop_at(7);
        step_cycle();
        check_eq("panel_lights", panel_lights, '0);
        check_idle(7);
        report_test("single_request", start);
    endtask

    task automatic lifo_order();
        int start;
        start = error_count;
        current_floor = 4'd0;
        car_state     = floor_pkg::UP_F1_F2;
        panel_buttons = one_hot(4);
        step_cycle();
        check_eq("activate", activate, 1'b0);
        panel_buttons = one_hot(9);
        step_cycle();
        check_eq("activate", activate, 1'b0);
        panel_buttons = one_hot(1);
        step_cycle();
        panel_buttons = '0;
        check_eq("activate", activate, 1'b0);
        check_eq("panel_lights", panel_lights, one_hot(1) | one_hot(4) | one_hot(9));
        stop_at(0);
        settle();
        check_eq("target_floor", target_floor, 1);
        check_eq("activate", activate, 1'b1);
        check_eq("direction_up", direction_up, 1'b1);
        // Serve the stack in order 1, 9, 4
        step_cycle();
        stop_at(1);
        step_cycle();
        check_eq("target_floor", target_floor, 9);
        stop_at(9);
        step_cycle();
        check_eq("target_floor", target_floor, 4);
        check_eq("direction_up", direction_up, 1'b0);
        stop_at(4);
        step_cycle();
        check_eq("panel_lights", panel_lights, '0);
        check_idle(4);
        report_test("lifo_order", start);
    endtask

    task automatic acceptance_rules();
        int start;
        start = error_count;
        stop_at(5);
        panel_buttons = one_hot(5);
        call_buttons  = one_hot(5);
        step_cycle();
        check_eq("panel_lights", panel_lights, '0);
        check_eq("call_lights", call_lights, '0);
        check_idle(5);
        // Panel 3 and hall 8 together, panel first
        panel_buttons = one_hot(3);
        call_buttons  = one_hot(8);
        step_cycle();
        check_eq("panel_lights", panel_lights, one_hot(3));
        check_eq("call_lights", call_lights, '0);
        step_cycle();
        check_eq("call_lights", call_lights, one_hot(8));
        panel_buttons = '0;
        call_buttons  = '0;
        settle();
        check_eq("target_floor", target_floor, 8);
        check_eq("activate", activate, 1'b1);
        check_eq("direction_up", direction_up, 1'b1);
        step_cycle();
        report_test("acceptance_rules", start);
    endtask

    // Floors 3 and 8 are still pending from the acceptance test
    task automatic flush_requests();
        int start;
        start = error_count;
        emergency = 1'b1;
        settle();
        check_idle(5);
        step_cycle();
        check_eq("panel_lights", panel_lights, '0);
        check_eq("call_lights", call_lights, '0);
        emergency     = 1'b0;
        power_switch  = 1'b0;
        panel_buttons = one_hot(9);
        step_cycle();
        check_eq("panel_lights", panel_lights, '0);
        check_idle(5);
        power_switch  = 1'b1;
        panel_buttons = '0;
        settle();
        check_idle(5);
        step_cycle();
        report_test("flush_requests", start);
    endtask

    task automatic door_permits();
        int          start;
        logic [31:0] r;
        logic        stopped;
        logic        ok;
        start = error_count;
        for (int i = 0; i < DOOR_ITERS; i++) begin
            r              = $random(seed);
            car_state      = floor_pkg::car_state_t'(r[4:0]);
            door_open_btn  = r[5];
            door_close_btn = r[6];
            emergency      = (r[10:8] == 3'd0);
            power_switch   = (r[13:11] != 3'd0);
            settle();
            stopped = (r[4:0] <= 5'd10);
            ok      = stopped && power_switch && !emergency;
            check_eq("door_open_allowed", door_open_allowed, r[5] && ok);
            check_eq("door_close_allowed", door_close_allowed, r[6] && ok);
            step_cycle();
        end
        door_open_btn  = 1'b0;
        door_close_btn = 1'b0;
        emergency      = 1'b0;
        power_switch   = 1'b1;
        stop_at(5);
        report_test("door_permits", start);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed           = 32'h340c;
        check_count    = 0;
        error_count    = 0;
        test_count     = 0;
        reset_n        = 1'b0;
        call_buttons   = '0;
        panel_buttons  = '0;
        door_open_btn  = 1'b0;
        door_close_btn = 1'b0;
        emergency      = 1'b0;
        power_switch   = 1'b1;
        current_floor  = 4'd0;
        car_state      = floor_pkg::STOP_FL1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        after_reset();
        single_request();
        lifo_order();
        acceptance_rules();
        flush_requests();
        door_permits();

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
hw/floor_pkg.sv
hw/request_if.sv
hw/request_lights.sv
hw/floor_stack.sv
hw/car_dispatch.sv
hw/floor_request_top.sv
sim/tb_floor_request.sv
